// File: Bender.yml
package:
  name: bdifcore

export_include_dirs:
  - hdl

sources:
  - hdl/bdIfPkg.sv
  - hdl/hostWordDecoder.sv
  - hdl/configRegs.sv
  - hdl/spikeGen.sv
  - hdl/bdDownMux.sv
  - hdl/bdUpPacker.sv
  - hdl/bdIfCore.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/bdIfCore_tb.sv

// File: hdl/bdDownMux.sv
`timescale 1ns/1ps

`include "bdIf_settings.svh"

module bdDownMux import bdIfPkg::*; (
  input  logic        sysClk,
  input  logic        rst,
  input  logic        bdWordStrobe,
  input  leaf_t       bdWordLeaf,
  input  logic [23:0] bdWordPayload,
  input  logic        spikeValid,
  input  bdOutWord_t  spikeWord,
  input  logic        bdOutReady,
  output logic        hostInFull,
  output logic        spikeTaken,
  output bdOutWord_t  bdOutData,
  output logic        bdOutValid
);

  localparam int Depth = `DOWN_FIFO_DEPTH;
  localparam int PtrW  = $clog2(`DOWN_FIFO_DEPTH);

  bdOutWord_t    fifoMem [Depth];
  logic [PtrW-1:0] wrPtr;  // pointers wrap on their own, depth is 2^n
  logic [PtrW-1:0] rdPtr;
  logic [PtrW:0] fifoCount;
  logic          push;
  logic          pop;
  logic          loadOut;

  // ------------------------------------------------------------------------
  // host chip-word FIFO
  // ------------------------------------------------------------------------
  assign hostInFull = (fifoCount == (PtrW + 1)'(Depth));
  assign push       = bdWordStrobe && !hostInFull;  // writes while full are lost

  always_ff @(posedge sysClk) begin
    if (push) begin
      fifoMem[wrPtr] <= {bdWordLeaf[4:0], bdWordPayload[15:0]};  // upper payload dropped
    end
  end

  always_ff @(posedge sysClk) begin
    if (rst) begin
      wrPtr     <= '0;
      rdPtr     <= '0;
      fifoCount <= '0;
    end else begin
      if (push) wrPtr <= wrPtr + 1'b1;
      if (pop) rdPtr <= rdPtr + 1'b1;
      fifoCount <= fifoCount + (PtrW + 1)'(push) - (PtrW + 1)'(pop);
    end
  end

  // ------------------------------------------------------------------------
  // arbitration and output register
  // ------------------------------------------------------------------------
  assign loadOut    = !bdOutValid || bdOutReady;  // empty or moving this edge
  assign pop        = loadOut && (fifoCount != '0);                 // host first
  assign spikeTaken = loadOut && (fifoCount == '0) && spikeValid;   // then spikes

  always_ff @(posedge sysClk) begin
    if (rst) begin
      bdOutValid <= 1'b0;
    end else if (loadOut) begin
      bdOutValid <= pop || spikeTaken;
    end
  end

  // data frozen while stalled
  always_ff @(posedge sysClk) begin
    if (pop) begin
      bdOutData <= fifoMem[rdPtr];
    end else if (spikeTaken) begin
      bdOutData <= spikeWord;
    end
  end

endmodule

// File: hdl/bdIfCore.sv
`timescale 1ns/1ps

module bdIfCore import bdIfPkg::*; (
  input  logic       sysClk,
  input  logic       rst,
  // host downstream
  input  hostWord_t  hostInData,
  input  logic       hostInWrite,
  output logic       hostInFull,
  // host upstream
  output hostWord_t  hostOutData,
  output logic       hostOutValid,
  input  logic       hostOutRead,
  // chip out
  output bdOutWord_t bdOutData,
  output logic       bdOutValid,
  input  logic       bdOutReady,
  // chip in
  input  bdInWord_t  bdInData,
  input  logic       bdInValid,
  output logic       bdInReady,
  output logic       bdReset
);

  // ------------------------------------------------------------------------
  // decoder outputs
  // ------------------------------------------------------------------------
  logic        bdWordStrobe;
  leaf_t       bdWordLeaf;
  logic [23:0] bdWordPayload;
  logic        regWrite;
  regId_t      regId;
  regData_t    regData;
  logic        chanWrite;
  regId_t      chanId;
  regData_t    chanData;

  // config and spikes
  regData_t    gensUsed;
  regData_t    genEnable;
  logic        spikeValid;
  bdOutWord_t  spikeWord;
  logic        spikeTaken;

  hostWordDecoder u_hostWordDecoder (
    .sysClk(sysClk), .rst(rst),
    .hostInData(hostInData), .hostInWrite(hostInWrite),
    .bdWordStrobe(bdWordStrobe), .bdWordLeaf(bdWordLeaf), .bdWordPayload(bdWordPayload),
    .regWrite(regWrite), .regId(regId), .regData(regData),
    .chanWrite(chanWrite), .chanId(chanId), .chanData(chanData)
  );

  configRegs u_configRegs (
    .sysClk(sysClk), .rst(rst),
    .regWrite(regWrite), .regId(regId), .regData(regData),
    .gensUsed(gensUsed), .genEnable(genEnable), .bdReset(bdReset)
  );

  spikeGen u_spikeGen (
    .sysClk(sysClk), .rst(rst),
    .chanWrite(chanWrite), .chanId(chanId), .chanData(chanData),
    .gensUsed(gensUsed), .genEnable(genEnable), .spikeTaken(spikeTaken),
    .spikeValid(spikeValid), .spikeWord(spikeWord)
  );

  bdDownMux u_bdDownMux (
    .sysClk(sysClk), .rst(rst),
    .bdWordStrobe(bdWordStrobe), .bdWordLeaf(bdWordLeaf), .bdWordPayload(bdWordPayload),
    .spikeValid(spikeValid), .spikeWord(spikeWord), .bdOutReady(bdOutReady),
    .hostInFull(hostInFull), .spikeTaken(spikeTaken),
    .bdOutData(bdOutData), .bdOutValid(bdOutValid)
  );

  bdUpPacker u_bdUpPacker (
    .sysClk(sysClk), .rst(rst),
    .bdInData(bdInData), .bdInValid(bdInValid), .hostOutRead(hostOutRead),
    .bdInReady(bdInReady), .hostOutData(hostOutData), .hostOutValid(hostOutValid)
  );

endmodule

// File: hdl/bdIfPkg.sv
`include "bdIf_settings.svh"

package bdIfPkg;

  // ----------------------------------------------------------------------
  // word types
  // ----------------------------------------------------------------------
  typedef logic [31:0] hostWord_t;            // host pipe word, both ways
  typedef logic [`BD_OUT_W-1:0] bdOutWord_t;  // chip downstream word
  typedef logic [`BD_IN_W-1:0] bdInWord_t;    // chip upstream word
  typedef logic [5:0] leaf_t;                 // horn leaf code

  // register / channel side
  typedef logic [15:0] regData_t;
  typedef logic [4:0] regId_t;

  // generator program, low to high:
  // tag[10:0] ticks[26:11] period[42:27] idx[50:43] sign[51], rest unused
  typedef logic [63:0] sgProgram_t;

  // host word classes, picked from bits 31:29
  typedef enum logic [1:0] {
    kindBd,
    kindReg,
    kindChan,
    kindDrop
  } wordKind_e;

endpackage

// File: hdl/bdIf_settings.svh
`ifndef BDIF_SETTINGS_SVH
`define BDIF_SETTINGS_SVH

// ------------------------------------------------------------------------
// chip port widths
// ------------------------------------------------------------------------
`define BD_OUT_W 21         // {leaf[4:0], payload[15:0]}
`define BD_IN_W 34          // raw upstream chip word

// ------------------------------------------------------------------------
// spike generators
// ------------------------------------------------------------------------
`define SG_NUM_GENS 4       // table entries
`define SG_TICK_DIV 8       // sysClk cycles per tick
`define SG_LEAF 30          // leaf code carried by spike words

// register numbers, endpoint minus 128
`define REG_GENS_USED 5
`define REG_GEN_ENABLE 6
`define REG_RESETS 31

`define DOWN_FIFO_DEPTH 4   // power of two

`endif

// File: hdl/bdUpPacker.sv
`timescale 1ns/1ps

module bdUpPacker import bdIfPkg::*; (
  input  logic      sysClk,
  input  logic      rst,
  input  bdInWord_t bdInData,
  input  logic      bdInValid,
  input  logic      hostOutRead,
  output logic      bdInReady,
  output hostWord_t hostOutData,
  output logic      hostOutValid
);

  hostWord_t holdWord [2];  // [0] low part, [1] high part
  logic      holdValid;
  logic      phase;         // which half goes out next
  logic      xfer;
  logic      popWord;

  // ------------------------------------------------------------------------
  // chip side, accept only with an empty buffer
  // ------------------------------------------------------------------------
  assign bdInReady = !holdValid;
  assign xfer      = bdInValid && bdInReady;
  assign popWord   = hostOutRead && holdValid;  // reads on empty are ignored

  always_ff @(posedge sysClk) begin
    if (xfer) begin
      holdWord[0] <= {8'hA0, bdInData[23:0]};
      holdWord[1] <= {8'hA1, 14'd0, bdInData[33:24]};
    end
  end

  always_ff @(posedge sysClk) begin
    if (rst) begin
      holdValid <= 1'b0;
      phase     <= 1'b0;
    end else if (xfer) begin
      holdValid <= 1'b1;
      phase     <= 1'b0;
    end else if (popWord) begin
      if (phase) begin
        holdValid <= 1'b0;  // both halves gone, reopen chip side
        phase     <= 1'b0;
      end else begin
        phase <= 1'b1;
      end
    end
  end

  // host side
  assign hostOutValid = holdValid;
  assign hostOutData  = holdWord[phase];

endmodule

// File: hdl/configRegs.sv
`timescale 1ns/1ps

`include "bdIf_settings.svh"

module configRegs import bdIfPkg::*; (
  input  logic     sysClk,
  input  logic     rst,
  input  logic     regWrite,
  input  regId_t   regId,
  input  regData_t regData,
  output regData_t gensUsed,
  output regData_t genEnable,
  output logic     bdReset
);

  logic [1:0] resetBits;  // {sReset, pReset}
  logic       hitGensUsed;
  logic       hitGenEnable;
  logic       hitResets;

  // ------------------------------------------------------------------------
  // address match
  // ------------------------------------------------------------------------
  assign hitGensUsed  = regWrite && (regId == regId_t'(`REG_GENS_USED));
  assign hitGenEnable = regWrite && (regId == regId_t'(`REG_GEN_ENABLE));
  assign hitResets    = regWrite && (regId == regId_t'(`REG_RESETS));
  // any other register number falls through untouched

  always_ff @(posedge sysClk) begin
    if (rst) begin
      gensUsed  <= '0;       // no generators live
      genEnable <= '0;
      resetBits <= 2'b11;    // chip held in reset until host clears it
    end else begin
      if (hitGensUsed) begin
        gensUsed <= regData;
      end
      if (hitGenEnable) begin
        genEnable <= regData;  // one bit per generator
      end
      if (hitResets) begin
        resetBits <= regData[1:0];
      end
    end
  end

  // either reset bit holds the chip
  assign bdReset = |resetBits;

endmodule

// File: hdl/hostWordDecoder.sv
`timescale 1ns/1ps

module hostWordDecoder import bdIfPkg::*; (
  input  logic        sysClk,
  input  logic        rst,
  input  hostWord_t   hostInData,
  input  logic        hostInWrite,
  output logic        bdWordStrobe,
  output leaf_t       bdWordLeaf,
  output logic [23:0] bdWordPayload,
  output logic        regWrite,
  output regId_t      regId,
  output regData_t    regData,
  output logic        chanWrite,
  output regId_t      chanId,
  output regData_t    chanData
);

  wordKind_e kind;

  // ------------------------------------------------------------------------
  // classify on the top three bits
  // ------------------------------------------------------------------------
  always_comb begin
    case (hostInData[31:29])
      3'b000,
      3'b001:  kind = kindBd;    // 00 + leaf, bit 29 is leaf msb
      3'b100:  kind = kindReg;   // regs 0..31
      3'b110:  kind = kindChan;  // channel writes
      default: kind = kindDrop;  // nop (reg 63), loopback prefix, etc
    endcase
  end

  // one strobe per accepted word
  always_ff @(posedge sysClk) begin
    if (rst) begin
      bdWordStrobe <= 1'b0;
      regWrite     <= 1'b0;
      chanWrite    <= 1'b0;
    end else begin
      bdWordStrobe <= hostInWrite && (kind == kindBd);
      regWrite     <= hostInWrite && (kind == kindReg);
      chanWrite    <= hostInWrite && (kind == kindChan);
    end
  end

  // field capture, only the matching set moves
  always_ff @(posedge sysClk) begin
    if (hostInWrite) begin
      if (kind == kindBd) begin
        bdWordLeaf    <= hostInData[29:24];
        bdWordPayload <= hostInData[23:0];
      end
      if (kind == kindReg) begin
        regId   <= hostInData[28:24];
        regData <= hostInData[15:0];  // bits 23:16 carry nothing
      end
      if (kind == kindChan) begin
        chanId   <= hostInData[28:24];
        chanData <= hostInData[15:0];
      end
    end
  end

endmodule

// File: hdl/spikeGen.sv
`timescale 1ns/1ps

`include "bdIf_settings.svh"

module spikeGen import bdIfPkg::*; (
  input  logic       sysClk,
  input  logic       rst,
  input  logic       chanWrite,
  input  regId_t     chanId,
  input  regData_t   chanData,
  input  regData_t   gensUsed,
  input  regData_t   genEnable,
  input  logic       spikeTaken,
  output logic       spikeValid,
  output bdOutWord_t spikeWord
);

  localparam int NumGens = `SG_NUM_GENS;
  localparam int TickW   = $clog2(`SG_TICK_DIV);
  localparam int SelW    = $clog2(`SG_NUM_GENS);

  sgProgram_t       progShift;  // pieces collected so far
  sgProgram_t       newProg;
  logic [1:0]       pieceCnt;
  logic             pieceWrite;
  logic             commit;
  logic [TickW-1:0] tickCnt;
  logic             tick;

  // generator table
  logic [15:0]      genPeriod [NumGens];
  logic [15:0]      genCount  [NumGens];
  logic [10:0]      genTag    [NumGens];
  logic             genSign   [NumGens];
  logic [NumGens-1:0] pending;
  logic [NumGens-1:0] fire;
  logic [SelW-1:0]  selIdx;

  // ------------------------------------------------------------------------
  // program assembly from channel 0
  // ------------------------------------------------------------------------
  assign pieceWrite = chanWrite && (chanId == '0);
  assign newProg    = {chanData, progShift[63:16]};  // newest piece lands on top
  assign commit     = pieceWrite && (pieceCnt == 2'd3);

  always_ff @(posedge sysClk) begin
    if (rst) begin
      pieceCnt <= '0;
    end else if (pieceWrite) begin
      pieceCnt <= pieceCnt + 2'd1;  // wraps after 4th piece
    end
  end

  always_ff @(posedge sysClk) begin
    if (pieceWrite) begin
      progShift <= newProg;
    end
  end

  // tick divider
  assign tick = (tickCnt == TickW'(`SG_TICK_DIV - 1));

  always_ff @(posedge sysClk) begin
    if (rst) begin
      tickCnt <= '0;
    end else begin
      tickCnt <= tick ? '0 : tickCnt + 1'b1;
    end
  end

  // fire when countdown hits 0, gated by gensUsed and enable bit
  always_comb begin
    for (int g = 0; g < NumGens; g++) begin
      fire[g] = tick && (genPeriod[g] != '0) && (genCount[g] == '0) &&
                (16'(g) < gensUsed) && genEnable[g];
    end
  end

  // ------------------------------------------------------------------------
  // countdowns and pending flags
  // ------------------------------------------------------------------------
  always_ff @(posedge sysClk) begin
    if (rst) begin
      for (int g = 0; g < NumGens; g++) begin
        genPeriod[g] <= '0;  // period 0 = idle entry
        genCount[g]  <= '0;
      end
      pending <= '0;
    end else begin
      for (int g = 0; g < NumGens; g++) begin
        if (commit && (newProg[50:43] == 8'(g))) begin  // idx >= NumGens never matches
          genPeriod[g] <= newProg[42:27];
          genCount[g]  <= newProg[26:11];
          pending[g]   <= 1'b0;  // drop stale spike of old program
        end else begin
          if (tick && (genPeriod[g] != '0)) begin
            genCount[g] <= (genCount[g] == '0) ? genPeriod[g] - 16'd1
                                               : genCount[g] - 16'd1;
          end
          // repeat fires merge into the waiting spike
          pending[g] <= fire[g] |
                        (pending[g] & ~(spikeTaken && (selIdx == SelW'(g))));
        end
      end
    end
  end

  always_ff @(posedge sysClk) begin
    for (int g = 0; g < NumGens; g++) begin
      if (commit && (newProg[50:43] == 8'(g))) begin
        genTag[g]  <= newProg[10:0];
        genSign[g] <= newProg[51];
      end
    end
  end

  // lowest pending index wins
  always_comb begin
    selIdx = '0;
    for (int g = NumGens - 1; g >= 0; g--) begin
      if (pending[g]) begin
        selIdx = SelW'(g);
      end
    end
  end

  assign spikeValid = |pending;
  assign spikeWord  = {5'(`SG_LEAF), genSign[selIdx], 4'b0000, genTag[selIdx]};

endmodule

// File: src.f
+incdir+hdl
+incdir+tb
hdl/bdIfPkg.sv
hdl/hostWordDecoder.sv
hdl/configRegs.sv
hdl/spikeGen.sv
hdl/bdDownMux.sv
hdl/bdUpPacker.sv
hdl/bdIfCore.sv
tb/bdIfCore_tb.sv

// File: tb/bdIfCoreVectors.svh
`ifndef BDIFCOREVECTORS_SVH
`define BDIFCOREVECTORS_SVH

// ------------------------------------------------------------------------
// downstream table: host word, expected chip word, hasOut = chip word due
// ------------------------------------------------------------------------
localparam int NumDown = 7;
localparam int NumUp   = 3;

hostWord_t  downIn     [NumDown];
bdOutWord_t downExpect [NumDown];
logic       downHasOut [NumDown];

// upstream table: chip word, then the two host words it splits into
bdInWord_t  upIn       [NumUp];
hostWord_t  upExpectLo [NumUp];
hostWord_t  upExpectHi [NumUp];

task automatic addDown(input int i, input hostWord_t w, input bdOutWord_t e,
                       input logic has);
  downIn[i]     = w;
  downExpect[i] = e;
  downHasOut[i] = has;
endtask

task automatic addUp(input int i, input bdInWord_t w, input hostWord_t lo,
                     input hostWord_t hi);
  upIn[i]       = w;
  upExpectLo[i] = lo;
  upExpectHi[i] = hi;
endtask

task automatic loadVectors();
  addDown(0, 32'h0512_3456, 21'h05_3456, 1'b1);  // leaf 5
  addDown(1, 32'h3FAB_CDEF, 21'h1F_CDEF, 1'b1);  // leaf msb and payload top cut
  addDown(2, 32'hBF00_0000, 21'h00_0000, 1'b0);  // nop, reg 63
  addDown(3, 32'hC100_1234, 21'h00_0000, 1'b0);  // channel 1, ignored
  addDown(4, 32'h2100_0001, 21'h01_0001, 1'b1);
  addDown(5, 32'h1AFF_0FF0, 21'h1A_0FF0, 1'b1);
  addDown(6, 32'h0000_0000, 21'h00_0000, 1'b1);  // all zero word still goes out
  addUp(0, 34'h3_FF12_3456, 32'hA012_3456, 32'hA100_03FF);
  addUp(1, 34'h1_5A00_00C3, 32'hA000_00C3, 32'hA100_015A);
  addUp(2, 34'h0_00FF_FFFF, 32'hA0FF_FFFF, 32'hA100_0000);
endtask

`endif

// File: tb/bdIfCore_tb.sv
`timescale 1ns/1ps

`include "bdIf_settings.svh"

module bdIfCore_tb import bdIfPkg::*; ();

  `include "bdIfCoreVectors.svh"

  localparam int TickDiv     = `SG_TICK_DIV;
  localparam int WindowTicks = 20;      // spike count window
  localparam int LogDepth    = 1024;
  localparam int CycleLimit  = 40 * (NumDown + NumUp) + 2000;

  logic       sysClk;
  logic       rst;
  hostWord_t  hostInData;
  logic       hostInWrite;
  logic       hostInFull;
  hostWord_t  hostOutData;
  logic       hostOutValid;
  logic       hostOutRead;
  bdOutWord_t bdOutData;
  logic       bdOutValid;
  logic       bdOutReady;
  bdInWord_t  bdInData;
  logic       bdInValid;
  logic       bdInReady;
  logic       bdReset;

  integer      seed = 32'hddbedf5f;
  logic [31:0] rnd;
  logic [1:0]  readyMode;               // 0 stall, 1 always ready, 2 random
  int          errorCount = 0;
  int          checkTotal = 0;
  int          cycleCount = 0;
  bdOutWord_t  outLog [LogDepth];       // every chip word that left
  int          outCount = 0;
  int          chipIdx [$];             // table rows that give a chip word

  bdIfCore u_bdIfCore (
    .sysClk(sysClk), .rst(rst),
    .hostInData(hostInData), .hostInWrite(hostInWrite), .hostInFull(hostInFull),
    .hostOutData(hostOutData), .hostOutValid(hostOutValid), .hostOutRead(hostOutRead),
    .bdOutData(bdOutData), .bdOutValid(bdOutValid), .bdOutReady(bdOutReady),
    .bdInData(bdInData), .bdInValid(bdInValid), .bdInReady(bdInReady),
    .bdReset(bdReset)
  );

  always #20 sysClk = ~sysClk;

  // ------------------------------------------------------------------------
  // ready driver, output monitor, watchdog
  // ------------------------------------------------------------------------
  always @(posedge sysClk) begin
    case (readyMode)
      2'd0: bdOutReady <= 1'b0;
      2'd1: bdOutReady <= 1'b1;
      default: begin
        rnd = $random(seed);
        bdOutReady <= rnd[0];
      end
    endcase
  end

  always @(posedge sysClk) begin
    if (!rst && bdOutValid && bdOutReady && outCount < LogDepth) begin
      outLog[outCount] <= bdOutData;
      outCount         <= outCount + 1;  // read after an edge = count before it
    end
  end

  always @(posedge sysClk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CycleLimit) begin
      $display("timeout: run stopped after %0d cycles", cycleCount);
      $display(">>> FAIL");
      $finish;
    end
  end

  // ------------------------------------------------------------------------
  // compare tasks and helpers
  // ------------------------------------------------------------------------
  task automatic checkBdWord(input string name, input bdOutWord_t expected,
                             input bdOutWord_t actual);
    checkTotal++;
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      errorCount++;
    end
  endtask

  task automatic checkHostWord(input string name, input hostWord_t expected,
                               input hostWord_t actual);
    checkTotal++;
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      errorCount++;
    end
  endtask

  task automatic checkLevel(input string name, input logic expected, input logic actual);
    checkTotal++;
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
      errorCount++;
    end
  endtask

  task automatic reportFailure(input string msg);
    $display("%s", msg);
    errorCount++;
  endtask

  function automatic hostWord_t regWord(input regId_t id, input regData_t d);
    return {3'b100, id, 8'h00, d};
  endfunction

  function automatic hostWord_t chanWord(input regId_t id, input regData_t d);
    return {3'b110, id, 8'h00, d};
  endfunction

  function automatic sgProgram_t makeProgram(input logic [7:0] idx, input logic sign,
                                             input logic [15:0] period,
                                             input logic [15:0] ticks,
                                             input logic [10:0] tag);
    sgProgram_t p;
    p        = '0;
    p[10:0]  = tag;
    p[26:11] = ticks;
    p[42:27] = period;
    p[50:43] = idx;
    p[51]    = sign;
    return p;
  endfunction

  // one write, then wait until FIFO and registers have it
  task automatic writeHost(input hostWord_t w);
    hostInData  <= w;
    hostInWrite <= 1'b1;
    @(posedge sysClk);
    hostInWrite <= 1'b0;
    repeat (2) @(posedge sysClk);
  endtask

  task automatic popHost();
    hostOutRead <= 1'b1;
    @(posedge sysClk);
    hostOutRead <= 1'b0;
    @(posedge sysClk);
  endtask

  task automatic writeProgram(input sgProgram_t prog);
    for (int p = 0; p < 4; p++) begin
      writeHost(chanWord(5'd0, prog[16*p +: 16]));  // low piece first
    end
  endtask

  task automatic measureSpikes(output int first, output int count);
    repeat (2 * TickDiv) @(posedge sysClk);  // older traffic settles
    first = outCount;
    repeat (WindowTicks * TickDiv) @(posedge sysClk);
    count = outCount - first;
  endtask

  task automatic waitOutputs(input int target);
    while (outCount < target) begin
      @(posedge sysClk);
    end
    repeat (30) @(posedge sysClk);  // room for a stray extra word
    if (outCount != target) begin
      reportFailure($sformatf("%0d chip words seen, %0d expected", outCount, target));
    end
  endtask

  // ------------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------------
  initial begin
    int         written;
    int         base;
    int         spikes;
    sgProgram_t prog;
    bdOutWord_t spikeExpect;

    sysClk      = 1'b0;
    rst         <= 1'b1;
    hostInData  <= '0;
    hostInWrite <= 1'b0;
    hostOutRead <= 1'b0;
    bdOutReady  <= 1'b0;
    bdInData    <= '0;
    bdInValid   <= 1'b0;
    readyMode   <= 2'd0;
    loadVectors();
    for (int i = 0; i < NumDown; i++) begin
      if (downHasOut[i]) begin
        chipIdx.push_back(i);
      end
    end
    repeat (4) @(posedge sysClk);
    rst <= 1'b0;
    @(posedge sysClk);

    // levels out of reset, then chip reset register
    checkLevel("reset bdReset", 1'b1, bdReset);
    checkLevel("reset bdOutValid", 1'b0, bdOutValid);
    checkLevel("reset hostOutValid", 1'b0, hostOutValid);
    checkLevel("reset hostInFull", 1'b0, hostInFull);
    checkLevel("reset bdInReady", 1'b1, bdInReady);
    writeHost(regWord(regId_t'(`REG_RESETS), 16'd0));
    checkLevel("resets cleared", 1'b0, bdReset);
    writeHost(regWord(regId_t'(`REG_RESETS), 16'd2));
    checkLevel("sReset set", 1'b1, bdReset);

    // table through the downstream path, random ready
    readyMode <= 2'd2;
    base = outCount;
    for (int i = 0; i < NumDown; i++) begin
      while (hostInFull) begin
        @(posedge sysClk);
      end
      writeHost(downIn[i]);
    end
    waitOutputs(base + chipIdx.size());
    for (int k = 0; k < chipIdx.size(); k++) begin
      checkBdWord($sformatf("down row %0d", chipIdx[k]), downExpect[chipIdx[k]],
                  outLog[base + k]);
    end

    // stalled chip port, fill until full
    readyMode <= 2'd0;
    @(posedge sysClk);
    base    = outCount;
    written = 0;
    while (!hostInFull && written < `DOWN_FIFO_DEPTH + 3) begin
      writeHost(downIn[chipIdx[written % chipIdx.size()]]);
      written++;
    end
    checkLevel("stall hostInFull", 1'b1, hostInFull);
    checkLevel("stall bdOutValid", 1'b1, bdOutValid);
    if (written != `DOWN_FIFO_DEPTH + 1) begin
      reportFailure($sformatf("hostInFull rose after %0d words, %0d expected", written,
                              `DOWN_FIFO_DEPTH + 1));
    end
    readyMode <= 2'd2;
    waitOutputs(base + written);
    for (int k = 0; k < written; k++) begin
      checkBdWord($sformatf("drain word %0d", k), downExpect[chipIdx[k % chipIdx.size()]],
                  outLog[base + k]);
    end
    checkLevel("drained hostInFull", 1'b0, hostInFull);

    // upstream split into two host words
    for (int i = 0; i < NumUp; i++) begin
      checkLevel($sformatf("up %0d ready before", i), 1'b1, bdInReady);
      bdInData  <= upIn[i];
      bdInValid <= 1'b1;
      @(posedge sysClk);  // transfer edge
      bdInValid <= 1'b0;
      while (!hostOutValid) begin
        @(posedge sysClk);
      end
      checkHostWord($sformatf("up %0d low", i), upExpectLo[i], hostOutData);
      checkLevel($sformatf("up %0d ready held", i), 1'b0, bdInReady);
      popHost();
      checkLevel($sformatf("up %0d second valid", i), 1'b1, hostOutValid);
      checkHostWord($sformatf("up %0d high", i), upExpectHi[i], hostOutData);
      checkLevel($sformatf("up %0d ready still held", i), 1'b0, bdInReady);
      popHost();
      checkLevel($sformatf("up %0d empty", i), 1'b0, hostOutValid);
      checkLevel($sformatf("up %0d ready again", i), 1'b1, bdInReady);
    end

    // generator 0, period 1, tag 5
    readyMode   <= 2'd1;
    prog        = makeProgram(8'd0, 1'b0, 16'd1, 16'd0, 11'd5);
    spikeExpect = {5'(`SG_LEAF), 1'b0, 4'b0000, 11'd5};
    writeProgram(prog);
    writeHost(regWord(regId_t'(`REG_GENS_USED), 16'd1));
    writeHost(regWord(regId_t'(`REG_GEN_ENABLE), 16'd1));
    measureSpikes(base, spikes);
    if (spikes < WindowTicks - 1 || spikes > WindowTicks + 1) begin
      reportFailure($sformatf("%0d spike words in %0d ticks", spikes, WindowTicks));
    end
    for (int k = 0; k < spikes; k++) begin
      checkBdWord($sformatf("spike %0d", k), spikeExpect, outLog[base + k]);
    end

    // enable bit off, reprogram, nothing may fire
    writeHost(regWord(regId_t'(`REG_GEN_ENABLE), 16'd0));
    writeProgram(prog);
    measureSpikes(base, spikes);
    if (spikes != 0) begin
      reportFailure($sformatf("%0d spike words with generator disabled", spikes));
    end

    $display("errors: %0d of %0d checks", errorCount, checkTotal);
    if (errorCount == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
